// File: ib.f
+incdir+.
ib_pkg.sv
ib_ctl.sv
ib_slots.sv
ib_debug_inject.sv
ib_top.sv
ib_props.sv
tb_ib.sv

// File: tb_ib.sv
// testbench for the instruction buffer
// random lane writes, decodes and flushes checked against a queue
// model, then debug commands injected into an empty buffer
`timescale 1ns/1ps
`include "ib_cfg.svh"

module tb_ib
   import ib_pkg::*;
();

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_RAND     = 3000;
   localparam int NUM_DBG      = 6;
   localparam int DBG_CYCLES   = 8;     // drain, command, check
   localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_RAND + NUM_DBG * DBG_CYCLES;

   typedef struct packed {
      logic      dbg;          // side data of a debug inst is don't care
      bp_data_t  bp;
      ib_entry_t e;
   } exp_t;

   logic                 clk;
   logic                 reset;
   logic                 i0_valid;
   logic                 i1_valid;
   ib_entry_t            i0_entry;
   ib_entry_t            i1_entry;
   bp_data_t             i0_bp;
   bp_data_t             i1_bp;
   logic                 dec_i0_decode;
   logic                 dec_i1_decode;
   logic                 flush;
   dbg_cmd_t             dbg_cmd;
   logic [`IB_DEPTH-1:0] ib_valid;
   ib_entry_t            i0_entry_d;
   ib_entry_t            i1_entry_d;
   bp_data_t             i0_bp_d;
   bp_data_t             i1_bp_d;
   logic                 debug_wdata_rs1_d;
   logic                 debug_fence_d;
   logic                 i0_debug_valid_d;

   exp_t        exp_q[$];              // slot 0 at the front
   logic        m_flush_q;
   logic        m_wdata;
   logic        m_fence;
   logic        m_dv;
   logic [31:0] lcg_state = 32'd43866;
   logic [30:0] seq = '0;             // unique pc per entry
   int          errors = 0;
   int          checks = 0;

   ib_top UUT (.*);

   function automatic logic [31:0] rand32();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic percent_hit(int pct);
      logic [31:0] r;
      r = rand32();
      return (r[31:16] % 100) < pct;
   endfunction

   function automatic ib_entry_t rand_entry(logic lane1);
      ib_entry_t   e;
      logic [31:0] r;
      r           = rand32();
      e.inst      = rand32();
      e.cinst     = r[31:16];
      e.pc        = seq;
      e.pc4       = r[15];
      e.icaf      = r[14] & r[13] & ~lane1;   // no faults on lane 1
      e.icaf_type = lane1 ? 2'b00 : r[12:11];
      e.dbecc     = r[10] & r[9] & ~lane1;
      e.br_valid  = r[8];
      seq         = seq + 1'b1;
      return e;
   endfunction

   function automatic bp_data_t rand_bp();
      logic [31:0] a;
      logic [31:0] b;
      a = rand32();
      b = rand32();
      return {a, b[24]};
   endfunction

   // or x0,reg,x0 / or reg,x0,x0 / csrrs x0,csr,x0 / csrrw x0,csr,x0
   function automatic logic [31:0] dbg_inst_ref(dbg_cmd_t cmd);
      logic [4:0]  r;
      logic [11:0] c;
      r = cmd.addr[4:0];
      c = cmd.addr[11:0];
      if (cmd.cmd_type == GPR)
         return cmd.write ? {17'h0, 3'b110, r, 7'h33} : {12'h0, r, 3'b110, 5'd0, 7'h33};
      if (cmd.cmd_type == CSR)
         return {c, 5'd0, cmd.write ? 3'b001 : 3'b010, 5'd0, 7'h73};
      return 32'h0;
   endfunction

   function automatic logic [3:0] fill_mask(int n);
      logic [3:0] m;
      m = '0;
      for (int k = 0; k < n; k++) begin
         m[k] = 1'b1;
      end
      return m;
   endfunction

   // advance the queue model and the debug flags by one clock edge
   function automatic void ref_step();
      int   pre;
      int   pop;
      logic dv;
      logic s0w;
      exp_t x;
      if (reset) begin
         exp_q.delete();
         {m_flush_q, m_wdata, m_fence, m_dv} = '0;
         return;
      end
      pre = exp_q.size();
      pop = dec_i0_decode ? (dec_i1_decode ? 2 : 1) : 0;
      for (int k = 0; k < pop; k++) begin
         if (exp_q.size() > 0) begin
            x = exp_q.pop_front();
         end
      end
      dv  = dbg_cmd.valid && dbg_cmd.cmd_type != MEM;
      s0w = pop > 0 && pre > pop;       // slot 0 refilled by the shift
      if (dv && exp_q.size() == 0) begin
         x             = {1'b1, i0_bp, i0_entry};
         x.e.inst      = dbg_inst_ref(dbg_cmd);
         x.e.icaf      = 1'b0;
         x.e.icaf_type = 2'b00;
         x.e.dbecc     = 1'b0;
         x.e.br_valid  = 1'b0;
         exp_q.push_back(x);
         s0w = 1'b1;
      end
      // room is judged before the shift and nothing is taken on flush_q or debug
      if (i0_valid && pre < 4 && !m_flush_q && !dv) begin
         if (exp_q.size() == 0) begin
            s0w = 1'b1;
         end
         exp_q.push_back({1'b0, i0_bp, i0_entry});
      end
      if (i1_valid && pre < 3 && !m_flush_q && !dv) begin
         exp_q.push_back({1'b0, i1_bp, i1_entry});
      end
      if (m_flush_q) begin
         exp_q.delete();
      end
      if (s0w) begin
         m_wdata = dv && dbg_cmd.write;
         m_fence = dv && dbg_cmd.write && dbg_cmd.cmd_type == CSR &&
                   dbg_cmd.addr[11:0] == 12'h7c4;
         m_dv    = dv;
      end
      m_flush_q = flush;
   endfunction

   task automatic report_mismatch(string msg);
      errors++;
      $display("Mismatch at %0t ns: %s", $time, msg);
   endtask

   task automatic check_outputs();
      int n;
      n = exp_q.size();
      checks++;
      assert (ib_valid == fill_mask(n))
         else report_mismatch($sformatf("ib_valid %b expected %b", ib_valid, fill_mask(n)));
      if (n > 0) begin
         assert (i0_entry_d == exp_q[0].e)
            else report_mismatch($sformatf("i0_entry_d %h expected %h", i0_entry_d, exp_q[0].e));
         assert (exp_q[0].dbg || i0_bp_d == exp_q[0].bp)
            else report_mismatch($sformatf("i0_bp_d %h expected %h", i0_bp_d, exp_q[0].bp));
      end
      if (n > 1) begin
         assert (i1_entry_d == exp_q[1].e)
            else report_mismatch($sformatf("i1_entry_d %h expected %h", i1_entry_d, exp_q[1].e));
         assert (exp_q[1].dbg || i1_bp_d == exp_q[1].bp)
            else report_mismatch($sformatf("i1_bp_d %h expected %h", i1_bp_d, exp_q[1].bp));
      end
      assert (debug_wdata_rs1_d == m_wdata && debug_fence_d == m_fence &&
              i0_debug_valid_d == (m_dv && n > 0))
         else report_mismatch($sformatf("debug flags %b%b%b expected %b%b%b",
            debug_wdata_rs1_d, debug_fence_d, i0_debug_valid_d, m_wdata, m_fence, m_dv && n > 0));
   endtask

   task automatic next_cycle();
      @(posedge clk);
      ref_step();
   endtask

   task automatic drive_random();
      int   n;
      logic v0;
      logic d0;
      n  = exp_q.size();
      v0 = percent_hit(70);
      d0 = n > 0 && percent_hit(45);
      i0_valid      <= v0;
      i1_valid      <= v0 && percent_hit(50);
      i0_entry      <= rand_entry(1'b0);
      i1_entry      <= rand_entry(1'b1);
      i0_bp         <= rand_bp();
      i1_bp         <= rand_bp();
      dec_i0_decode <= d0;
      dec_i1_decode <= d0 && n > 1 && percent_hit(50);
      flush         <= percent_hit(3);
   endtask

   // stop the aligner and decode until the buffer is empty
   task automatic drain();
      i0_valid <= 1'b0;
      i1_valid <= 1'b0;
      flush    <= 1'b0;
      dbg_cmd  <= '0;
      while (exp_q.size() > 0 || m_flush_q) begin
         dec_i0_decode <= exp_q.size() > 0;
         dec_i1_decode <= exp_q.size() > 1;
         next_cycle();
      end
      dec_i0_decode <= 1'b0;
      dec_i1_decode <= 1'b0;
   endtask

   task automatic run_debug(logic write, dbg_type_e t, logic [31:0] addr);
      dbg_cmd_t cmd;
      drain();
      cmd.valid    = 1'b1;
      cmd.write    = write;
      cmd.cmd_type = t;
      cmd.addr     = addr;
      dbg_cmd  <= cmd;
      i0_valid <= 1'b1;                 // must lose against the command
      i0_entry <= rand_entry(1'b0);
      i0_bp    <= rand_bp();
      next_cycle();
      dbg_cmd  <= '0;
      i0_valid <= 1'b0;
      @(negedge clk);
      assert (i0_debug_valid_d == (t != MEM) && debug_wdata_rs1_d == (write && t != MEM) &&
              debug_fence_d == (write && t == CSR && addr[11:0] == 12'h7c4))
         else report_mismatch($sformatf("debug flags wrong for command %h", cmd));
      next_cycle();
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      reset         = 1'b1;
      i0_valid      = 1'b0;
      i1_valid      = 1'b0;
      i0_entry      = '0;
      i1_entry      = '0;
      i0_bp         = '0;
      i1_bp         = '0;
      dec_i0_decode = 1'b0;
      dec_i1_decode = 1'b0;
      flush         = 1'b0;
      dbg_cmd       = '0;
      repeat (RESET_CYCLES) next_cycle();
      reset <= 1'b0;
      for (int i = 0; i < NUM_RAND; i++) begin
         next_cycle();
         drive_random();
      end
      run_debug(1'b1, MEM, 32'h7c4);    // ignored and sets no fence
      run_debug(1'b0, GPR, rand32());
      run_debug(1'b1, GPR, rand32());
      run_debug(1'b0, CSR, 32'h7c4);
      run_debug(1'b1, CSR, 32'h300);
      run_debug(1'b1, CSR, 32'h7c4);
      drain();
      repeat (2) next_cycle();
      $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
               checks, errors, UUT.u_ctl.u_props.fails);
      if (errors == 0 && UUT.u_ctl.u_props.fails == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   always @(negedge clk) begin
      if (!reset) begin
         check_outputs();
      end
   end

   initial begin
      #(TOTAL_CYCLES * CLK_PERIOD * 3 / 2);
      $display("watchdog expired before the test sequence finished");
      $display("tests failed");
      $finish;
   end

endmodule

// File: ib_props.sv
// instruction buffer invariants, bound into the controller
// valids stay contiguous from slot 0, flush_q empties the buffer,
// decode enables only on valid slots and i1 only with i0
`timescale 1ns/1ps
`include "ib_cfg.svh"

module ib_props (
   input logic                 clk,
   input logic                 reset,
   input logic [`IB_DEPTH-1:0] ib_valid,
   input logic                 flush_q,
   input logic                 dec_i0_decode,
   input logic                 dec_i1_decode
);

   int fails = 0;   // failed assertion count

   // a thermometer code has no set bit above a clear one
   a_contiguous: assert property (@(posedge clk) disable iff (reset)
      (ib_valid & (ib_valid + 1'b1)) == '0)
   else begin
      $error("slot valids %b are not contiguous from slot 0", ib_valid);
      fails++;
   end

   a_flush_clears: assert property (@(posedge clk) disable iff (reset)
      flush_q |=> ib_valid == '0)
   else begin
      $error("buffer not empty one cycle after flush_q");
      fails++;
   end

   a_i1_with_i0: assert property (@(posedge clk) disable iff (reset)
      dec_i1_decode |-> dec_i0_decode)
   else begin
      $error("i1 decoded without i0");
      fails++;
   end

   a_decode_valid: assert property (@(posedge clk) disable iff (reset)
      (dec_i0_decode |-> ib_valid[0]) and (dec_i1_decode |-> ib_valid[1]))
   else begin
      $error("decode of an empty slot");
      fails++;
   end

endmodule

bind ib_ctl ib_props u_props (
   .clk           (clk),
   .reset         (reset),
   .ib_valid      (ib_valid),
   .flush_q       (flush_q),
   .dec_i0_decode (dec_i0_decode),
   .dec_i1_decode (dec_i1_decode)
);

// File: ib_top.sv
// instruction buffer top
// four-slot buffer between the aligner and the dual-issue decoder.
// the controller steers writes and shifts, the injector replaces lane 0
// with debug instructions, and two slot arrays hold the instruction
// entries and the branch prediction side data
`timescale 1ns/1ps
`include "ib_cfg.svh"

module ib_top
   import ib_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,

   input  logic                 i0_valid,
   input  logic                 i1_valid,
   input  ib_entry_t            i0_entry,
   input  ib_entry_t            i1_entry,      // no faults on lane 1
   input  bp_data_t             i0_bp,
   input  bp_data_t             i1_bp,

   input  logic                 dec_i0_decode,
   input  logic                 dec_i1_decode,
   input  logic                 flush,         // from execute
   input  dbg_cmd_t             dbg_cmd,

   output logic [`IB_DEPTH-1:0] ib_valid,      // aligner back-pressure
   output ib_entry_t            i0_entry_d,
   output ib_entry_t            i1_entry_d,
   output bp_data_t             i0_bp_d,
   output bp_data_t             i1_bp_d,
   output logic                 debug_wdata_rs1_d,
   output logic                 debug_fence_d,
   output logic                 i0_debug_valid_d
);

   ib_ctl_vec_t slot_ctl;
   logic        slot0_write;
   logic        dbg_valid;
   ib_entry_t   lane0_entry;

   ib_ctl u_ctl (
      .clk           (clk),
      .reset         (reset),
      .i0_valid      (i0_valid),
      .i1_valid      (i1_valid),
      .dec_i0_decode (dec_i0_decode),
      .dec_i1_decode (dec_i1_decode),
      .flush         (flush),
      .dbg_valid     (dbg_valid),
      .ib_valid      (ib_valid),
      .slot_ctl      (slot_ctl),
      .slot0_write   (slot0_write)
   );

   ib_debug_inject u_debug_inject (
      .clk               (clk),
      .reset             (reset),
      .dbg_cmd           (dbg_cmd),
      .i0_entry          (i0_entry),
      .slot0_write       (slot0_write),
      .slot0_valid       (ib_valid[0]),
      .dbg_valid         (dbg_valid),
      .lane0_entry       (lane0_entry),
      .debug_wdata_rs1_d (debug_wdata_rs1_d),
      .debug_fence_d     (debug_fence_d),
      .i0_debug_valid_d  (i0_debug_valid_d)
   );

   ib_slots #(.payload_t(ib_entry_t)) u_entry_slots (
      .clk      (clk),
      .slot_ctl (slot_ctl),
      .lane0    (lane0_entry),   // i0 or debug inst
      .lane1    (i1_entry),
      .slot0    (i0_entry_d),
      .slot1    (i1_entry_d)
   );

   // side data for a debug inst is don't care
   ib_slots #(.payload_t(bp_data_t)) u_bp_slots (
      .clk      (clk),
      .slot_ctl (slot_ctl),
      .lane0    (i0_bp),
      .lane1    (i1_bp),
      .slot0    (i0_bp_d),
      .slot1    (i1_bp_d)
   );

endmodule

// File: ib_debug_inject.sv
// debug command injector
// turns a gpr or csr access from the debugger into an or / csrrs /
// csrrw instruction and puts it on lane 0 in place of the aligner's i0.
// write-data-on-rs1, debug fence and debug valid are taken with slot 0
`timescale 1ns/1ps
`include "ib_cfg.svh"

module ib_debug_inject
   import ib_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  dbg_cmd_t  dbg_cmd,
   input  ib_entry_t i0_entry,
   input  logic      slot0_write,
   input  logic      slot0_valid,
   output logic      dbg_valid,
   output ib_entry_t lane0_entry,
   output logic      debug_wdata_rs1_d,
   output logic      debug_fence_d,
   output logic      i0_debug_valid_d
);

   logic               rd_gpr;
   logic               wr_gpr;
   logic               rd_csr;
   logic               wr_csr;
   logic [4:0]         dreg;
   logic [11:0]        dcsr;
   logic [`INST_W-1:0] dbg_inst;
   logic               fence_in;
   logic               dbg_valid_q;

   // memory access is done elsewhere
   assign dbg_valid = dbg_cmd.valid & (dbg_cmd.cmd_type != MEM);

   assign rd_gpr = dbg_valid & ~dbg_cmd.write & (dbg_cmd.cmd_type == GPR);
   assign wr_gpr = dbg_valid &  dbg_cmd.write & (dbg_cmd.cmd_type == GPR);
   assign rd_csr = dbg_valid & ~dbg_cmd.write & (dbg_cmd.cmd_type == CSR);
   assign wr_csr = dbg_valid &  dbg_cmd.write & (dbg_cmd.cmd_type == CSR);

   assign dreg = dbg_cmd.addr[4:0];
   assign dcsr = dbg_cmd.addr[11:0];

   always_comb begin
      dbg_inst = '0;
      if (rd_gpr) begin
         // or x0,reg,x0   register read lands on rs1
         dbg_inst = {12'h000, dreg, `DBG_F3_OR, 5'd0, `DBG_OPC_OP};
      end else if (wr_gpr) begin
         // or reg,x0,x0   write data is forced onto rs1
         dbg_inst = {7'd0, 5'd0, 5'd0, `DBG_F3_OR, dreg, `DBG_OPC_OP};
      end else if (rd_csr) begin
         dbg_inst = {dcsr, 5'd0, `DBG_F3_CSRRS, 5'd0, `DBG_OPC_SYSTEM};  // csrrs x0,csr,x0
      end else if (wr_csr) begin
         dbg_inst = {dcsr, 5'd0, `DBG_F3_CSRRW, 5'd0, `DBG_OPC_SYSTEM};  // csrrw x0,csr,x0
      end
   end

   // debug inst carries no faults and no prediction
   always_comb begin
      lane0_entry = i0_entry;
      if (dbg_valid) begin
         lane0_entry.inst      = dbg_inst;
         lane0_entry.icaf      = 1'b0;
         lane0_entry.icaf_type = 2'b00;
         lane0_entry.dbecc     = 1'b0;
         lane0_entry.br_valid  = 1'b0;
      end
   end

   assign fence_in = wr_csr & (dcsr == `DBG_FENCE_CSR);

   always_ff @(posedge clk) begin
      if (reset) begin
         debug_wdata_rs1_d <= 1'b0;
         debug_fence_d     <= 1'b0;
         dbg_valid_q       <= 1'b0;
      end else if (slot0_write) begin
         debug_wdata_rs1_d <= wr_gpr | wr_csr;
         debug_fence_d     <= fence_in;
         dbg_valid_q       <= dbg_valid;
      end
   end

   assign i0_debug_valid_d = dbg_valid_q & slot0_valid;

endmodule

// File: ib_slots.sv
// shifting slot array
// IB_DEPTH payload registers. each one loads lane 0, lane 1 or the
// entry one or two slots above when its write enable is set; the
// two oldest slots go out to decode. serves entries and bp side data
`timescale 1ns/1ps
`include "ib_cfg.svh"

module ib_slots
   import ib_pkg::*;
#(
   parameter type payload_t = logic
) (
   input  logic        clk,
   input  ib_ctl_vec_t slot_ctl,
   input  payload_t    lane0,
   input  payload_t    lane1,
   output payload_t    slot0,
   output payload_t    slot1
);

   payload_t slot_q [`IB_DEPTH];

   for (genvar k = 0; k < `IB_DEPTH; k++) begin : g_slot
      payload_t up1;
      payload_t up2;
      payload_t nxt;

      // top slots have nothing above and the controller never picks UP there
      if (k + 1 < `IB_DEPTH) begin : g_up1
         assign up1 = slot_q[k+1];
      end else begin : g_up1_none
         assign up1 = lane1;
      end

      if (k + 2 < `IB_DEPTH) begin : g_up2
         assign up2 = slot_q[k+2];
      end else begin : g_up2_none
         assign up2 = lane1;
      end

      always_comb begin
         case (slot_ctl[k].src)
            LANE0:   nxt = lane0;
            LANE1:   nxt = lane1;
            UP1:     nxt = up1;
            default: nxt = up2;
         endcase
      end

      always_ff @(posedge clk) begin
         if (slot_ctl[k].we) begin
            slot_q[k] <= nxt;
         end
      end
   end

   assign slot0 = slot_q[0];   // i0 at decode
   assign slot1 = slot_q[1];   // i1 at decode

endmodule

// File: ib_ctl.sv
// instruction buffer controller
// holds the slot valids and the registered flush, turns the decode
// enables into a shift of 0, 1 or 2 and places the accepted lanes in
// the first free slots after that shift. a debug command is a lane 0
// write that may only land in slot 0
`timescale 1ns/1ps
`include "ib_cfg.svh"

module ib_ctl
   import ib_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 i0_valid,
   input  logic                 i1_valid,
   input  logic                 dec_i0_decode,
   input  logic                 dec_i1_decode,
   input  logic                 flush,
   input  logic                 dbg_valid,
   output logic [`IB_DEPTH-1:0] ib_valid,
   output ib_ctl_vec_t          slot_ctl,
   output logic                 slot0_write
);

   logic                 flush_q;
   logic                 shift1;
   logic                 shift2;
   logic                 i0_acc;
   logic                 i1_acc;
   logic                 dbg_wr;
   logic [`IB_DEPTH-1:0] shift_val;    // valids once decoded entries leave
   logic [`IB_DEPTH-1:0] first_free;   // one-hot
   logic [`IB_DEPTH-1:0] i0_wr;
   logic [`IB_DEPTH-1:0] i1_wr;
   logic [`IB_DEPTH-1:0] l0_wr;
   logic [`IB_DEPTH+1:0] val_ext;      // two empty slots past the top
   logic [`IB_DEPTH-1:0] up1;
   logic [`IB_DEPTH-1:0] up2;
   logic [`IB_DEPTH-1:0] valid_in;

   // flush from execute arrives late, take it a cycle later
   always_ff @(posedge clk) begin
      if (reset) begin
         flush_q <= 1'b0;
      end else begin
         flush_q <= flush;
      end
   end

   assign shift1 = dec_i0_decode ^ dec_i1_decode;
   assign shift2 = dec_i0_decode & dec_i1_decode;

   always_comb begin
      shift_val = ib_valid;
      if (shift2) begin
         shift_val = ib_valid >> 2;
      end else if (shift1) begin
         shift_val = ib_valid >> 1;
      end
   end

   // room is judged on the valids before the shift
   assign i0_acc = i0_valid & ~ib_valid[`IB_DEPTH-1] & ~flush_q & ~dbg_valid;
   assign i1_acc = i1_valid & ~ib_valid[`IB_DEPTH-2] & ~flush_q & ~dbg_valid;

   assign first_free = {shift_val[`IB_DEPTH-2:0], 1'b1} & ~shift_val;

   assign i0_wr  = first_free & {`IB_DEPTH{i0_acc}};
   assign i1_wr  = {first_free[`IB_DEPTH-2:0], 1'b0} & {`IB_DEPTH{i1_acc}};
   assign dbg_wr = dbg_valid & ~shift_val[0];   // only into an empty buffer
   assign l0_wr  = i0_wr | {{(`IB_DEPTH-1){1'b0}}, dbg_wr};

   // a slot takes from above only if that slot holds something
   assign val_ext = {2'b00, ib_valid};
   assign up1     = {`IB_DEPTH{shift1}} & val_ext[`IB_DEPTH:1];
   assign up2     = {`IB_DEPTH{shift2}} & val_ext[`IB_DEPTH+1:2];

   // lane targets sit above every shifted entry, so the sources never overlap
   always_comb begin
      for (int k = 0; k < `IB_DEPTH; k++) begin
         slot_ctl[k].we = l0_wr[k] | i1_wr[k] | up1[k] | up2[k];
         if (i1_wr[k]) begin
            slot_ctl[k].src = LANE1;
         end else if (up1[k]) begin
            slot_ctl[k].src = UP1;
         end else if (up2[k]) begin
            slot_ctl[k].src = UP2;
         end else begin
            slot_ctl[k].src = LANE0;
         end
      end
   end

   assign valid_in = (shift_val | l0_wr | i1_wr) & ~{`IB_DEPTH{flush_q}};

   always_ff @(posedge clk) begin
      if (reset) begin
         ib_valid <= '0;
      end else begin
         ib_valid <= valid_in;
      end
   end

   assign slot0_write = slot_ctl[0].we;  // debug flags load with slot 0

endmodule

// File: ib_pkg.sv
// instruction buffer types
// buffered instruction entry, branch prediction side data,
// per-slot control from the controller and the debugger command
`include "ib_cfg.svh"

package ib_pkg;

   // one aligned instruction as held in a slot
   typedef struct packed {
      logic [`INST_W-1:0]  inst;
      logic [`CINST_W-1:0] cinst;       // 16b form of a compressed inst
      logic [`PC_W-1:0]    pc;
      logic                pc4;         // 4B inst else 2B
      logic                icaf;        // access fault
      logic [1:0]          icaf_type;
      logic                dbecc;       // double-bit ecc error
      logic                br_valid;    // predicted branch
   } ib_entry_t;

   // btb side data, kept in its own slot array
   typedef struct packed {
      logic [`BP_INDEX_W-1:0]   index;
      logic [`BP_GHR_W-1:0]     ghr;
      logic [`BP_TAG_W-1:0]     tag;
      logic [`BP_TOFFSET_W-1:0] toffset;
   } bp_data_t;

   // where a slot loads from
   typedef enum logic [1:0] {
      LANE0 = 2'd0,     // aligner i0 or debug inst
      LANE1 = 2'd1,     // aligner i1
      UP1   = 2'd2,     // slot above
      UP2   = 2'd3      // two slots above
   } ib_src_e;

   typedef struct packed {
      logic    we;
      ib_src_e src;
   } ib_slot_ctl_t;

   typedef ib_slot_ctl_t [`IB_DEPTH-1:0] ib_ctl_vec_t;

   typedef enum logic [1:0] {
      GPR = 2'd0,
      CSR = 2'd1,
      MEM = 2'd2        // abstract memory access, not handled here
   } dbg_type_e;

   typedef struct packed {
      logic                   valid;
      logic                   write;
      dbg_type_e              cmd_type;
      logic [`DBG_ADDR_W-1:0] addr;      // gpr in [4:0], csr in [11:0]
   } dbg_cmd_t;

endpackage

// File: ib_cfg.svh
// instruction buffer configuration
// slot depth, payload widths and the debug instruction encodings
`ifndef IB_CFG_SVH
`define IB_CFG_SVH

`define IB_DEPTH       4

`define INST_W         32
`define CINST_W        16
`define PC_W           31        // pc[31:1]

`define BP_INDEX_W     8
`define BP_GHR_W       8
`define BP_TAG_W       5
`define BP_TOFFSET_W   12

`define DBG_ADDR_W     32

// debug-only fence csr
`define DBG_FENCE_CSR  12'h7c4

// fields of the synthesized debug instructions
`define DBG_OPC_OP     7'b0110011
`define DBG_OPC_SYSTEM 7'b1110011
`define DBG_F3_OR      3'b110
`define DBG_F3_CSRRW   3'b001
`define DBG_F3_CSRRS   3'b010

`endif
